/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --assert --timing -j 0
TOP       := packet_mem_tb
FLIST     := flist.f
OBJ_DIR   := obj_dir
RUN_ARGS  := +verilator+error+limit+1000
PASS_MSG  := ALL CHECKS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* common/packet_pkg.sv */
// packet memory shared types: packet word, sram address, port structs and controller states
package packet_pkg;

    // one packet word, same width as the receiver's parallel word
    typedef logic [15:0] packet_t;

    // 64-line packet sram
    typedef logic [5:0] sram_addr_t;

    // datapath write-back
    typedef struct packed {
        logic    valid;
        packet_t packet;
    } dp_wb_t;

    // write-back from one edge PE
    typedef struct packed {
        logic    valid;
        packet_t packet;
    } edge_wb_t;

    // single sram port, wen is active low
    typedef struct packed {
        logic       wen;
        sram_addr_t addr;
        packet_t    data;
    } sram_req_t;

    typedef struct packed {
        logic    valid;
        packet_t packet;
    } fifo_push_t;

    typedef enum logic [2:0] {
        idle,
        prepare,
        stream,
        wait_stall,
        halt
    } cntl_state_t;

endpackage

/* flist.f */
common/packet_pkg.sv
source/packet_rx.sv
source/packet_sram.sv
source/packet_fifo.sv
packet_cntl/packet_cntl.sv
source/packet_mem_top.sv
sim/packet_mem_asserts.sv
sim/packet_mem_tb.sv

/* packet_cntl/packet_cntl.sv */
// packet memory controller, loads packets then arbitrates write-backs and reads into the FIFO
`timescale 1ns/1ps

module packet_cntl #(
    parameter int unsigned NUM_EDGE_PE = 4
) (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   rx_valid,
    input  packet_pkg::packet_t                    rx_packet,
    input  logic                                   rx_last,
    input  packet_pkg::dp_wb_t                     dp_wb,
    input  packet_pkg::edge_wb_t [NUM_EDGE_PE-1:0] edge_wb,
    input  logic                                   replay,
    input  logic                                   fifo_stall,
    input  logic                                   cntl_done,
    input  logic                                   full,
    input  packet_pkg::packet_t                    rd_packet,
    output packet_pkg::sram_req_t                  sram_req,
    output packet_pkg::fifo_push_t                 push,
    output logic                                   load_done
);

    localparam packet_pkg::sram_addr_t ADDR_ONE = 1;

    packet_pkg::cntl_state_t state;
    packet_pkg::cntl_state_t next_state;
    packet_pkg::sram_addr_t  wr_ptr;
    packet_pkg::sram_addr_t  next_wr_ptr;
    packet_pkg::sram_addr_t  rd_ptr;
    packet_pkg::sram_addr_t  next_rd_ptr;
    logic                    next_load_done;
    logic                    rd_issue;
    logic                    rd_issue_q;
    logic                    edge_any;
    packet_pkg::packet_t     edge_packet;

    // highest-index valid edge PE wins, the rest are dropped
    always_comb begin
        edge_any = 1'b0;
        edge_packet = '0;
        for (int i = 0; i < NUM_EDGE_PE; i++) begin
            if (edge_wb[i].valid) begin
                edge_any = 1'b1;
                edge_packet = edge_wb[i].packet;
            end
        end
    end

    // read only when the port is free and there is unread data
    assign rd_issue = (state == packet_pkg::stream)
                      && !dp_wb.valid
                      && !edge_any
                      && (rd_ptr != wr_ptr)
                      && !full
                      && !replay
                      && !fifo_stall
                      && !cntl_done;

    always_comb begin
        next_state = state;
        next_wr_ptr = wr_ptr;
        next_rd_ptr = rd_ptr;
        next_load_done = load_done;
        sram_req.wen = 1'b1;
        sram_req.addr = '0;
        sram_req.data = '0;

        case (state)
            // load phase, write pointer doubles as the load address
            packet_pkg::idle, packet_pkg::prepare: begin
                if (rx_valid) begin
                    sram_req.wen = 1'b0;
                    sram_req.addr = wr_ptr;
                    sram_req.data = rx_packet;
                    next_wr_ptr = wr_ptr + ADDR_ONE;
                    if (rx_last) begin
                        next_state = packet_pkg::stream;
                        next_load_done = 1'b1;
                    end else begin
                        next_state = packet_pkg::prepare;
                    end
                end
            end

            packet_pkg::stream, packet_pkg::wait_stall: begin
                if (dp_wb.valid) begin
                    sram_req.wen = 1'b0;
                    sram_req.addr = wr_ptr;
                    sram_req.data = dp_wb.packet;
                    next_wr_ptr = wr_ptr + ADDR_ONE;
                end else if (edge_any) begin
                    sram_req.wen = 1'b0;
                    sram_req.addr = wr_ptr;
                    sram_req.data = edge_packet;
                    next_wr_ptr = wr_ptr + ADDR_ONE;
                end else if (rd_issue) begin
                    sram_req.addr = rd_ptr;
                    next_rd_ptr = rd_ptr + ADDR_ONE;
                end

                if (cntl_done) begin
                    next_state = packet_pkg::halt;
                end else if (replay) begin
                    // rewind reads only, stored write-backs stay
                    next_state = packet_pkg::stream;
                    next_rd_ptr = '0;
                end else if (fifo_stall) begin
                    next_state = packet_pkg::wait_stall;
                end else begin
                    next_state = packet_pkg::stream;
                end
            end

            // halt: port idle until reset
            default: begin
                next_state = state;
            end
        endcase
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state <= packet_pkg::idle;
            wr_ptr <= '0;
            rd_ptr <= '0;
            load_done <= 1'b0;
            rd_issue_q <= 1'b0;
        end else begin
            state <= next_state;
            wr_ptr <= next_wr_ptr;
            rd_ptr <= next_rd_ptr;
            load_done <= next_load_done;
            rd_issue_q <= rd_issue;
        end
    end

    // sram read data arrives the cycle after the issue
    assign push.valid = rd_issue_q;
    assign push.packet = rd_packet;

endmodule

/* sim/packet_mem_asserts.sv */
// packet memory assertions for FIFO room, stall, halt, write-back priority and reset values
`timescale 1ns/1ps

module packet_mem_asserts #(
    parameter int unsigned FIFO_DEPTH = 8
) (
    input logic                                clk,
    input logic                                reset,
    input packet_pkg::cntl_state_t             state,
    input packet_pkg::sram_req_t               sram_req,
    input packet_pkg::fifo_push_t              push,
    input logic [$clog2(FIFO_DEPTH + 1)-1:0]   count,
    input packet_pkg::dp_wb_t                  dp_wb,
    input logic                                fifo_stall,
    input logic                                out_valid,
    input logic                                load_done
);

    localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);

    int unsigned fail_count = 0;

    // the spare slot must absorb the in-flight read
    a_push_room: assert property (@(posedge clk) disable iff (!reset)
        push.valid |-> count != CNT_W'(FIFO_DEPTH))
    else begin
        $error("push arrived while the FIFO already held FIFO_DEPTH packets");
        fail_count++;
    end

    // no read issued during a stall, so no push the cycle after
    a_stall_no_read: assert property (@(posedge clk) disable iff (!reset)
        fifo_stall |=> !push.valid)
    else begin
        $error("read issued while fifo_stall was high");
        fail_count++;
    end

    a_halt_quiet: assert property (@(posedge clk) disable iff (!reset)
        state == packet_pkg::halt |-> sram_req.wen && !push.valid)
    else begin
        $error("sram write or FIFO push after halt");
        fail_count++;
    end

    // datapath write-back owns the port over edge write-backs and reads
    a_dp_first: assert property (@(posedge clk) disable iff (!reset)
        dp_wb.valid && (state == packet_pkg::stream || state == packet_pkg::wait_stall)
        |-> !sram_req.wen && sram_req.data == dp_wb.packet)
    else begin
        $error("datapath write-back did not win the sram port");
        fail_count++;
    end

    // first edge with reset released
    a_reset_low: assert property (@(posedge clk)
        $rose(reset) |-> !push.valid && !out_valid && !load_done)
    else begin
        $error("push, out_valid or load_done high right after reset");
        fail_count++;
    end

endmodule

/* sim/packet_mem_tb.sv */
// packet memory testbench: serial load, write-backs, back-pressure, stall, replay and halt
`timescale 1ns/1ps

module packet_mem_tb;

    localparam int NUM_EDGE_PE = 4;
    localparam int FIFO_DEPTH = 8;
    localparam int LOAD_COUNT = 6;
    localparam int MAX_CYCLES = 4000;

    logic                                   clk;
    logic                                   reset;
    logic                                   sos;
    logic                                   eos;
    logic                                   serial_data;
    packet_pkg::dp_wb_t                     dp_wb;
    packet_pkg::edge_wb_t [NUM_EDGE_PE-1:0] edge_wb;
    logic                                   replay;
    logic                                   fifo_stall;
    logic                                   cntl_done;
    logic                                   pop;
    logic                                   out_valid;
    packet_pkg::packet_t                    out_packet;
    logic                                   load_done;

    // expected sram contents in address order
    packet_pkg::packet_t model[$];
    int    base = 0;
    int    pops = 0;
    int    checks = 0;
    int    errors = 0;
    int    cycles = 0;
    int    target;
    int    assert_fails;
    string test_name = "reset";

    packet_mem_top #(
        .NUM_EDGE_PE (NUM_EDGE_PE),
        .FIFO_DEPTH  (FIFO_DEPTH)
    ) dut0 (.*);

    bind packet_mem_top packet_mem_asserts #(.FIFO_DEPTH(FIFO_DEPTH)) asserts0 (
        .clk(clk), .reset(reset), .state(cntl0.state), .sram_req(sram_req),
        .push(push), .count(fifo0.count), .dp_wb(dp_wb), .fifo_stall(fifo_stall),
        .out_valid(out_valid), .load_done(load_done)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // head is popped at the coming edge, compare mid-cycle
    always @(negedge clk) begin
        if (reset && pop && out_valid) begin
            if (pops - base >= model.size()) begin
                $display("error in %s: FIFO returned more packets than were stored", test_name);
                errors++;
            end else if (out_packet !== model[pops - base]) begin
                $display("[FAIL] %s: expected %h, actual %h", test_name,
                         model[pops - base], out_packet);
                errors++;
            end
            checks++;
            pops++;
        end
    end

    function automatic packet_pkg::packet_t rand_packet();
        return packet_pkg::packet_t'($urandom());
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic send_load(input int count);
        packet_pkg::packet_t word;
        for (int p = 0; p < count; p++) begin
            word = rand_packet();
            model.push_back(word);
            for (int b = 15; b >= 0; b--) begin
                sos = (p == 0) && (b == 15);
                eos = (p == count - 1) && (b == 0);
                serial_data = word[b];
                next_cycle();
            end
        end
        sos = 1'b0;
        eos = 1'b0;
        serial_data = 1'b0;
    endtask

    task automatic write_dp(input int count);
        for (int i = 0; i < count; i++) begin
            dp_wb.valid = 1'b1;
            dp_wb.packet = rand_packet();
            model.push_back(dp_wb.packet);
            next_cycle();
        end
        dp_wb = '0;
    endtask

    task automatic drain_to(input int total);
        pop = 1'b1;
        while (pops < total) begin
            next_cycle();
        end
    endtask

    initial begin
        reset = 1'b0;
        sos = 1'b0;
        eos = 1'b0;
        serial_data = 1'b0;
        dp_wb = '0;
        edge_wb = '0;
        replay = 1'b0;
        fifo_stall = 1'b0;
        cntl_done = 1'b0;
        pop = 1'b0;
        void'($urandom(32'ha470));
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b1;
        next_cycle();

        test_name = "load";
        send_load(LOAD_COUNT);
        while (!load_done) begin
            next_cycle();
        end
        drain_to(LOAD_COUNT);

        // dp beats both edges, then edge 3 beats edge 0
        test_name = "write_back_priority";
        edge_wb[1].valid = 1'b1;
        edge_wb[1].packet = rand_packet();
        edge_wb[2].valid = 1'b1;
        edge_wb[2].packet = rand_packet();
        write_dp(1);
        edge_wb = '0;
        edge_wb[0].valid = 1'b1;
        edge_wb[0].packet = rand_packet();
        edge_wb[3].valid = 1'b1;
        edge_wb[3].packet = rand_packet();
        model.push_back(edge_wb[3].packet);
        next_cycle();
        edge_wb = '0;
        drain_to(model.size());

        test_name = "back_pressure";
        pop = 1'b0;
        write_dp(10);
        while (!dut0.full) begin
            next_cycle();
        end
        repeat (4) next_cycle();
        drain_to(model.size());

        test_name = "fifo_stall";
        fifo_stall = 1'b1;
        next_cycle();
        write_dp(3);
        edge_wb[2].valid = 1'b1;
        edge_wb[2].packet = rand_packet();
        model.push_back(edge_wb[2].packet);
        next_cycle();
        edge_wb = '0;
        repeat (3) next_cycle();
        fifo_stall = 1'b0;
        drain_to(model.size());

        test_name = "replay";
        target = pops + model.size();
        base = pops;
        replay = 1'b1;
        next_cycle();
        replay = 1'b0;
        drain_to(target);

        // write-backs offered during halt must not reach the sram
        test_name = "halt";
        cntl_done = 1'b1;
        dp_wb.valid = 1'b1;
        dp_wb.packet = rand_packet();
        next_cycle();
        cntl_done = 1'b0;
        repeat (3) next_cycle();
        dp_wb = '0;
        repeat (4) next_cycle();

        assert_fails = dut0.asserts0.fail_count;
        $display("checks %0d, value errors %0d, assertion failures %0d",
                 checks, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* source/packet_fifo.sv */
// output FIFO toward the PEs, full flag raised one slot early for the in-flight read
`timescale 1ns/1ps

module packet_fifo #(
    parameter int unsigned FIFO_DEPTH = 8
) (
    input  logic                   clk,
    input  logic                   reset,
    input  packet_pkg::fifo_push_t push,
    input  logic                   pop,
    output logic                   full,
    output logic                   out_valid,
    output packet_pkg::packet_t    out_packet
);

    localparam int unsigned PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);

    packet_pkg::packet_t buf_mem [FIFO_DEPTH];
    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;
    logic [CNT_W-1:0]    count;
    logic                do_push;
    logic                do_pop;

    // wrap for depths that are not a power of two
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + PTR_W'(1);
    endfunction

    assign do_push = push.valid && (count != CNT_W'(FIFO_DEPTH));
    assign do_pop = pop && (count != '0);

    assign out_valid = (count != '0);
    assign out_packet = buf_mem[rd_ptr];
    // one spare slot left for the read already issued to the sram
    assign full = (count >= CNT_W'(FIFO_DEPTH - 1));

    always_ff @(posedge clk) begin
        if (do_push) begin
            buf_mem[wr_ptr] <= push.packet;
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10: count <= count + CNT_W'(1);
                2'b01: count <= count - CNT_W'(1);
                default: count <= count;
            endcase
        end
    end

endmodule

/* source/packet_mem_top.sv */
// packet memory subsystem: serial receiver, controller, packet sram and output FIFO
`timescale 1ns/1ps

module packet_mem_top #(
    parameter int unsigned NUM_EDGE_PE = 4,
    parameter int unsigned FIFO_DEPTH = 8
) (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   sos,
    input  logic                                   eos,
    input  logic                                   serial_data,
    input  packet_pkg::dp_wb_t                     dp_wb,
    input  packet_pkg::edge_wb_t [NUM_EDGE_PE-1:0] edge_wb,
    input  logic                                   replay,
    input  logic                                   fifo_stall,
    input  logic                                   cntl_done,
    input  logic                                   pop,
    output logic                                   out_valid,
    output packet_pkg::packet_t                    out_packet,
    output logic                                   load_done
);

    logic                   rx_valid;
    packet_pkg::packet_t    rx_packet;
    logic                   rx_last;
    packet_pkg::sram_req_t  sram_req;
    packet_pkg::packet_t    rd_packet;
    packet_pkg::fifo_push_t push;
    logic                   full;

    packet_rx rx0 (
        .clk         (clk),
        .reset       (reset),
        .sos         (sos),
        .eos         (eos),
        .serial_data (serial_data),
        .rx_valid    (rx_valid),
        .rx_packet   (rx_packet),
        .rx_last     (rx_last)
    );

    packet_cntl #(
        .NUM_EDGE_PE (NUM_EDGE_PE)
    ) cntl0 (
        .clk        (clk),
        .reset      (reset),
        .rx_valid   (rx_valid),
        .rx_packet  (rx_packet),
        .rx_last    (rx_last),
        .dp_wb      (dp_wb),
        .edge_wb    (edge_wb),
        .replay     (replay),
        .fifo_stall (fifo_stall),
        .cntl_done  (cntl_done),
        .full       (full),
        .rd_packet  (rd_packet),
        .sram_req   (sram_req),
        .push       (push),
        .load_done  (load_done)
    );

    packet_sram sram0 (
        .clk       (clk),
        .reset     (reset),
        .sram_req  (sram_req),
        .rd_packet (rd_packet)
    );

    packet_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) fifo0 (
        .clk        (clk),
        .reset      (reset),
        .push       (push),
        .pop        (pop),
        .full       (full),
        .out_valid  (out_valid),
        .out_packet (out_packet)
    );

endmodule

/* source/packet_rx.sv */
// serial loader receiver, frames msb-first bits into 16-bit packets between sos and eos
`timescale 1ns/1ps

module packet_rx (
    input  logic                clk,
    input  logic                reset,
    input  logic                sos,
    input  logic                eos,
    input  logic                serial_data,
    output logic                rx_valid,
    output packet_pkg::packet_t rx_packet,
    output logic                rx_last
);

    localparam int unsigned PACKET_W = $bits(packet_pkg::packet_t);
    localparam int unsigned CNT_W = $clog2(PACKET_W);

    logic                active;
    logic [CNT_W-1:0]    bit_cnt;
    logic                eos_seen;
    logic                take_bit;
    logic                word_done;
    packet_pkg::packet_t shift_q;

    // sos carries the first bit, so a word can never close on that cycle
    assign take_bit = sos || active;
    assign word_done = active && !sos && (bit_cnt == CNT_W'(PACKET_W - 1));

    // shift register holds the finished word while rx_valid is high
    always_ff @(posedge clk) begin
        if (take_bit) begin
            shift_q <= {shift_q[PACKET_W-2:0], serial_data};
        end
    end

    assign rx_packet = shift_q;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            active <= 1'b0;
            bit_cnt <= '0;
            eos_seen <= 1'b0;
            rx_valid <= 1'b0;
            rx_last <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            if (sos) begin
                active <= 1'b1;
                bit_cnt <= CNT_W'(1);
                eos_seen <= eos;
            end else if (word_done) begin
                rx_valid <= 1'b1;
                rx_last <= eos || eos_seen;
                bit_cnt <= '0;
                eos_seen <= 1'b0;
                // stream ends with this word, wait for the next sos
                if (eos || eos_seen) begin
                    active <= 1'b0;
                end
            end else if (active) begin
                bit_cnt <= bit_cnt + CNT_W'(1);
                if (eos) begin
                    eos_seen <= 1'b1;
                end
            end
        end
    end

endmodule

/* source/packet_sram.sv */
// single-port packet sram, active-low write enable, registered read data
`timescale 1ns/1ps

module packet_sram (
    input  logic                  clk,
    input  logic                  reset,
    input  packet_pkg::sram_req_t sram_req,
    output packet_pkg::packet_t   rd_packet
);

    localparam int unsigned SRAM_LINES = 2 ** $bits(packet_pkg::sram_addr_t);

    packet_pkg::packet_t mem [SRAM_LINES];

    // write lands at the clock edge
    always_ff @(posedge clk) begin
        if (!sram_req.wen) begin
            mem[sram_req.addr] <= sram_req.data;
        end
    end

    // read data one cycle after the request
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            rd_packet <= '0;
        end else if (sram_req.wen) begin
            rd_packet <= mem[sram_req.addr];
        end
    end

endmodule
